/* source/oflow_core_pkg.sv */
// data path widths and types for the matching stage
// widths are fixed here, no module overrides them
package oflow_core_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int SCORE_LEN = 10;                     // SAD score, max real sum 1020
	localparam int ID_LEN    = 3;                      // entry id, 8 entries
	localparam int ELEM_LEN  = 8;                      // one feature element
	localparam int NUM_ELEMS = 4;                      // elements per feature
	localparam int FEAT_LEN  = ELEM_LEN * NUM_ELEMS;   // packed feature, element 0 in low bits

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [SCORE_LEN-1:0] score_t;
	typedef logic [ID_LEN-1:0]    id_t;
	typedef logic [FEAT_LEN-1:0]  feature_t;

	// all ones, above any real SAD, marks empty slots and cleared minima
	localparam score_t MAX_SCORE = '1;

endpackage

/* source/oflow_ctrl_pkg.sv */
// control side definitions: host opcodes, controller states, entry count limits
// entry_count holds 1..8 only, the config block clamps anything else
package oflow_ctrl_pkg;

	localparam int NUM_ENTRIES = 8;    // feature memory depth
	localparam int COUNT_LEN   = 4;    // wide enough to hold 8

	typedef logic [COUNT_LEN-1:0] count_t;

	localparam count_t MIN_COUNT = count_t'(1);
	localparam count_t MAX_COUNT = count_t'(NUM_ENTRIES);

	// ----------------------------------------
	// host config opcodes
	// ----------------------------------------
	typedef enum logic [1:0] {
		OP_WRITE_FEAT = 2'd0,   // cfg_data -> entry cfg_addr
		OP_SET_QUERY  = 2'd1,   // cfg_data -> query
		OP_SET_COUNT  = 2'd2,   // cfg_data low bits -> entry_count
		OP_START      = 2'd3    // one cycle start pulse
	} cfg_op_t;

	// ----------------------------------------
	// match controller states
	// ----------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,        // pair address on the memory
		ST_SCORE,       // features out, metrics registering
		ST_MIN,         // calc_min merging the pair
		ST_WAIT_MIN,    // done_calc_min back
		ST_REQ,         // result_req high
		ST_RELEASE      // waiting for result_ack low
	} match_state_t;

endpackage

/* source/oflow_feature_mem.sv */
// eight entry stored feature memory, one write port, two registered read ports
// read during write of the same entry returns the old data
`timescale 1ns/1ns

module oflow_feature_mem (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic                      we,
	input  oflow_core_pkg::id_t       waddr,
	input  oflow_core_pkg::feature_t  wdata,
	input  oflow_core_pkg::id_t       rd_addr_0,   // even slot
	input  oflow_core_pkg::id_t       rd_addr_1,   // odd slot
	output oflow_core_pkg::feature_t  rd_feat_0,
	output oflow_core_pkg::feature_t  rd_feat_1
);
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	feature_t mem [NUM_ENTRIES];   // no reset, host loads before a search

	// host write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// both reads registered, one cycle latency
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_feat_0 <= '0;
			rd_feat_1 <= '0;
		end else begin
			rd_feat_0 <= mem[rd_addr_0];
			rd_feat_1 <= mem[rd_addr_1];
		end
	end

endmodule

/* source/oflow_similarity_metric.sv */
// sum of absolute differences over four 8-bit elements, registered
// an invalid slot scores MAX_SCORE so a real entry always beats it
`timescale 1ns/1ns

module oflow_similarity_metric (
	input  logic                      clk,
	input  logic                      reset_N,
	input  oflow_core_pkg::feature_t  query,
	input  oflow_core_pkg::feature_t  stored,
	input  logic                      slot_valid,
	input  oflow_core_pkg::id_t       id_in,
	output oflow_core_pkg::score_t    score,
	output oflow_core_pkg::id_t       id
);
	import oflow_core_pkg::*;

	score_t sad;

	always_comb begin
		logic [ELEM_LEN-1:0] q_e;
		logic [ELEM_LEN-1:0] s_e;
		logic [ELEM_LEN-1:0] diff;
		sad = '0;
		for (int i = 0; i < NUM_ELEMS; i++) begin
			q_e  = query[i*ELEM_LEN +: ELEM_LEN];
			s_e  = stored[i*ELEM_LEN +: ELEM_LEN];
			diff = (q_e > s_e) ? (q_e - s_e) : (s_e - q_e);   // |q - s|
			sad  = sad + score_t'(diff);                       // 4 x 255 fits in 10 bits
		end
	end

	// score and id stay aligned
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			score <= MAX_SCORE;
			id    <= '0;
		end else begin
			score <= slot_valid ? sad : MAX_SCORE;
			id    <= id_in;
		end
	end

endmodule

/* source/oflow_calc_min.sv */
// tracks the best and second best score across one search
// ties: stored minimum kept unless strictly beaten, even slot wins inside a pair
`timescale 1ns/1ns

module oflow_calc_min (
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    start_score_calc,   // clears minima, once per search
	input  logic                    start_calc_min,     // one per pair
	output logic                    done_calc_min,
	input  oflow_core_pkg::score_t  score_0,
	input  oflow_core_pkg::score_t  score_1,
	input  oflow_core_pkg::id_t     id_0,
	input  oflow_core_pkg::id_t     id_1,
	output oflow_core_pkg::score_t  min_score_0,        // best
	output oflow_core_pkg::score_t  min_score_1,        // second best
	output oflow_core_pkg::id_t     min_id_0,
	output oflow_core_pkg::id_t     min_id_1
);
	import oflow_core_pkg::*;

	typedef enum logic {idle_st, calc_min_st} sm_type;

	sm_type current_state;
	sm_type next_state;

	score_t best_nxt, sec_nxt;
	id_t    best_id_nxt, sec_id_nxt;
	logic   lt0_best, lt1_best, lt0_sec, lt1_sec, s0_le_s1;

	// ----------------------------------------
	// compares against the stored pair
	// ----------------------------------------
	assign lt0_best = score_0 < min_score_0;
	assign lt1_best = score_1 < min_score_0;
	assign lt0_sec  = score_0 < min_score_1;
	assign lt1_sec  = score_1 < min_score_1;
	assign s0_le_s1 = score_0 <= score_1;   // even slot wins a tie

	always_comb begin
		next_state  = (current_state == idle_st && start_calc_min) ? calc_min_st : idle_st;
		best_nxt    = min_score_0;
		best_id_nxt = min_id_0;
		sec_nxt     = min_score_1;
		sec_id_nxt  = min_id_1;
		if (lt0_best && lt1_best) begin   // both new scores beat the best
			best_nxt    = s0_le_s1 ? score_0 : score_1;
			best_id_nxt = s0_le_s1 ? id_0 : id_1;
			sec_nxt     = s0_le_s1 ? score_1 : score_0;
			sec_id_nxt  = s0_le_s1 ? id_1 : id_0;
		end else if (lt0_best || lt1_best) begin
			// one new best, old best drops to second
			best_nxt    = lt0_best ? score_0 : score_1;
			best_id_nxt = lt0_best ? id_0 : id_1;
			sec_nxt     = min_score_0;
			sec_id_nxt  = min_id_0;
		end else if (lt0_sec && lt1_sec) begin
			sec_nxt     = s0_le_s1 ? score_0 : score_1;
			sec_id_nxt  = s0_le_s1 ? id_0 : id_1;
		end else if (lt0_sec || lt1_sec) begin
			sec_nxt     = lt0_sec ? score_0 : score_1;
			sec_id_nxt  = lt0_sec ? id_0 : id_1;
		end
	end

	// ----------------------------------------
	// state and done
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			current_state <= idle_st;
			done_calc_min <= 1'b0;
		end else begin
			current_state <= next_state;
			done_calc_min <= (current_state == calc_min_st);   // same edge as the update
		end
	end

	// minima, cleared at search start
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			min_score_0 <= MAX_SCORE;
			min_score_1 <= MAX_SCORE;
			min_id_0    <= '0;
			min_id_1    <= '0;
		end else if (start_score_calc) begin
			min_score_0 <= MAX_SCORE;
			min_score_1 <= MAX_SCORE;
			min_id_0    <= '0;
			min_id_1    <= '0;
		end else if (current_state == calc_min_st) begin
			min_score_0 <= best_nxt;
			min_score_1 <= sec_nxt;
			min_id_0    <= best_id_nxt;
			min_id_1    <= sec_id_nxt;
		end
	end

	// controller must wait for done before the next pair
	a_no_start_while_calc: assert property (@(posedge clk) disable iff (!reset_N)
		start_calc_min |-> current_state == idle_st);

endmodule

/* source/oflow_match_ctrl.sv */
// steps the stored entries two at a time, then offers the result on a four-phase port
// start is ignored until the previous result is released
`timescale 1ns/1ns

module oflow_match_ctrl (
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    start,
	input  oflow_ctrl_pkg::count_t  entry_count,
	output oflow_core_pkg::id_t     rd_addr_0,
	output oflow_core_pkg::id_t     rd_addr_1,
	output logic                    slot_valid_1,
	output logic                    start_score_calc,
	output logic                    start_calc_min,
	input  logic                    done_calc_min,
	output logic                    result_req,
	input  logic                    result_ack
);
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	match_state_t state, state_nxt;

	logic [ID_LEN-2:0] pair_q;   // pair index, ids 2p and 2p+1
	count_t            next_even;
	logic              last_pair;

	// ----------------------------------------
	// pair addressing
	// ----------------------------------------
	assign rd_addr_0    = {pair_q, 1'b0};
	assign rd_addr_1    = {pair_q, 1'b1};
	assign slot_valid_1 = count_t'(rd_addr_1) < entry_count;   // odd slot past the end scores max
	assign next_even    = count_t'(rd_addr_0) + count_t'(2);
	assign last_pair    = next_even >= entry_count;

	// strobes decoded from state
	assign start_score_calc = (state == ST_IDLE) && start;
	assign start_calc_min   = (state == ST_SCORE);   // sampled on the edge the scores land
	assign result_req       = (state == ST_REQ);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:     if (start) state_nxt = ST_READ;
			ST_READ:     state_nxt = ST_SCORE;
			ST_SCORE:    state_nxt = ST_MIN;
			ST_MIN:      state_nxt = ST_WAIT_MIN;
			ST_WAIT_MIN: begin
				if (done_calc_min) begin
					state_nxt = last_pair ? ST_REQ : ST_READ;
				end
			end
			ST_REQ:      if (result_ack) state_nxt = ST_RELEASE;
			ST_RELEASE:  if (!result_ack) state_nxt = ST_IDLE;
			default:     state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state  <= ST_IDLE;
			pair_q <= '0;
		end else begin
			state <= state_nxt;
			if (start_score_calc) begin
				pair_q <= '0;                // new search from entry 0
			end else if (state == ST_WAIT_MIN && done_calc_min && !last_pair) begin
				pair_q <= pair_q + 1'b1;
			end
		end
	end

	// scoreboard acks only a result on offer
	a_ack_on_req: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(result_ack) |-> result_req);

endmodule

/* source/oflow_cfg_regs.sv */
// host config block, one four-phase command per req rise
// count 0 is taken as 1, counts above 8 as 8
`timescale 1ns/1ns

module oflow_cfg_regs (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic                      cfg_req,
	input  oflow_ctrl_pkg::cfg_op_t   cfg_op,
	input  oflow_core_pkg::id_t       cfg_addr,
	input  oflow_core_pkg::feature_t  cfg_data,
	output logic                      cfg_ack,
	output logic                      mem_we,
	output oflow_core_pkg::id_t       mem_waddr,
	output oflow_core_pkg::feature_t  mem_wdata,
	output oflow_core_pkg::feature_t  query,
	output oflow_ctrl_pkg::count_t    entry_count,
	output logic                      start
);
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	logic   req_rise;
	count_t req_count;
	count_t count_clamped;

	// ack follows req a cycle late, so req high with ack low is a new command
	assign req_rise  = cfg_req && !cfg_ack;
	assign req_count = cfg_data[COUNT_LEN-1:0];

	always_comb begin
		if (req_count < MIN_COUNT) count_clamped = MIN_COUNT;
		else if (req_count > MAX_COUNT) count_clamped = MAX_COUNT;
		else count_clamped = req_count;
	end

	// ----------------------------------------
	// control and config state
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cfg_ack     <= 1'b0;
			mem_we      <= 1'b0;
			start       <= 1'b0;
			query       <= '0;
			entry_count <= MAX_COUNT;
		end else begin
			cfg_ack <= cfg_req;   // held while req stays high
			mem_we  <= 1'b0;      // pulses
			start   <= 1'b0;
			if (req_rise) begin
				case (cfg_op)
					OP_WRITE_FEAT: mem_we      <= 1'b1;
					OP_SET_QUERY:  query       <= cfg_data;
					OP_SET_COUNT:  entry_count <= count_clamped;
					OP_START:      start       <= 1'b1;
					default:       ;
				endcase
			end
		end
	end

	// write payload, lines up with mem_we
	always_ff @(posedge clk) begin
		if (req_rise && cfg_op == OP_WRITE_FEAT) begin
			mem_waddr <= cfg_addr;
			mem_wdata <= cfg_data;
		end
	end

	// host keeps req up until it has seen ack
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(cfg_ack) |-> cfg_req);

endmodule

/* source/oflow_match_top.sv */
// matching stage top: config block, controller, feature memory, two metrics, min finder
// result valid only while result_req is high
`timescale 1ns/1ns

module oflow_match_top (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic                      cfg_req,
	input  oflow_ctrl_pkg::cfg_op_t   cfg_op,
	input  oflow_core_pkg::id_t       cfg_addr,
	input  oflow_core_pkg::feature_t  cfg_data,
	output logic                      cfg_ack,
	output logic                      result_req,
	input  logic                      result_ack,
	output oflow_core_pkg::score_t    min_score_0,
	output oflow_core_pkg::id_t       min_id_0,
	output oflow_core_pkg::score_t    min_score_1,
	output oflow_core_pkg::id_t       min_id_1
);
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	// ----------------------------------------
	// internal wires
	// ----------------------------------------
	logic     mem_we, start, slot_valid_1;
	id_t      mem_waddr, rd_addr_0, rd_addr_1, id_0, id_1;
	feature_t mem_wdata, query, rd_feat_0, rd_feat_1;
	count_t   entry_count;
	score_t   score_0, score_1;
	logic     start_score_calc, start_calc_min, done_calc_min;

	oflow_cfg_regs u_cfg_regs (
		.clk, .reset_N, .cfg_req, .cfg_op, .cfg_addr, .cfg_data, .cfg_ack,
		.mem_we, .mem_waddr, .mem_wdata, .query, .entry_count, .start
	);

	oflow_match_ctrl u_match_ctrl (
		.clk, .reset_N, .start, .entry_count, .rd_addr_0, .rd_addr_1, .slot_valid_1,
		.start_score_calc, .start_calc_min, .done_calc_min, .result_req, .result_ack
	);

	oflow_feature_mem u_feature_mem (
		.clk, .reset_N, .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
		.rd_addr_0, .rd_addr_1, .rd_feat_0, .rd_feat_1
	);

	// even slot always below entry_count
	oflow_similarity_metric u_metric_0 (
		.clk, .reset_N, .query, .stored(rd_feat_0), .slot_valid(1'b1),
		.id_in(rd_addr_0), .score(score_0), .id(id_0)
	);

	oflow_similarity_metric u_metric_1 (
		.clk, .reset_N, .query, .stored(rd_feat_1), .slot_valid(slot_valid_1),
		.id_in(rd_addr_1), .score(score_1), .id(id_1)
	);

	oflow_calc_min u_calc_min (
		.clk, .reset_N, .start_score_calc, .start_calc_min, .done_calc_min,
		.score_0, .score_1, .id_0, .id_1,
		.min_score_0, .min_score_1, .min_id_0, .min_id_1
	);

endmodule

/* tb/oflow_match_tb.sv */
// directed testbench for the matching stage, host config port and result port driven here
// expected minima come from a SAD model over a mirror of the written entries
// every wait polls at negedge with its own limit, stimulus changes on posedge
`timescale 1ns/1ns

module oflow_match_tb;
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	localparam int WAIT_LIMIT = 200;   // cycles, longest search is 17

	logic     clk;
	logic     reset_N;
	logic     cfg_req;
	cfg_op_t  cfg_op;
	id_t      cfg_addr;
	feature_t cfg_data;
	logic     cfg_ack;
	logic     result_req;
	logic     result_ack;
	score_t   min_score_0, min_score_1;
	id_t      min_id_0, min_id_1;

	// model state, mirrors what the host wrote
	feature_t feat_ref [NUM_ENTRIES];
	feature_t query_ref;
	int       count_ref;

	// result taken when result_req rose
	score_t res_s0, res_s1;
	id_t    res_i0, res_i1;

	int errors;
	int checks;
	int tests;

	oflow_match_top u_oflow_match_top (
		.clk, .reset_N, .cfg_req, .cfg_op, .cfg_addr, .cfg_data, .cfg_ack,
		.result_req, .result_ack, .min_score_0, .min_id_0, .min_score_1, .min_id_1
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// ----------------------------------------
	// compares and reporting
	// ----------------------------------------
	task automatic check_score(string name, score_t exp, score_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected score %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_id(string name, id_t exp, id_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected id %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic abort_run(string what);
		$display("ERROR: %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic report_test(string name, int errs_at_start);
		tests++;
		$display("%-14s %s", name, (errors == errs_at_start) ? "ok" : "errors");
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic score_t sad_ref(feature_t q, feature_t s);
		int sum;
		int d;
		sum = 0;
		for (int e = 0; e < NUM_ELEMS; e++) begin
			d   = int'(q[e*ELEM_LEN +: ELEM_LEN]) - int'(s[e*ELEM_LEN +: ELEM_LEN]);
			sum = sum + ((d < 0) ? -d : d);
		end
		return score_t'(sum);
	endfunction

	// lower score wins, ascending scan so the lower id keeps a tie
	task automatic check_model(string name);
		score_t best_s, sec_s, s;
		id_t    best_i, sec_i;
		best_s = MAX_SCORE;
		sec_s  = MAX_SCORE;
		best_i = '0;
		sec_i  = '0;
		for (int i = 0; i < count_ref; i++) begin
			s = sad_ref(query_ref, feat_ref[i]);
			if (s < best_s) begin
				sec_s  = best_s;
				sec_i  = best_i;
				best_s = s;
				best_i = id_t'(i);
			end else if (s < sec_s) begin
				sec_s = s;
				sec_i = id_t'(i);
			end
		end
		check_score(name, best_s, res_s0);
		check_id(name, best_i, res_i0);
		check_score(name, sec_s, res_s1);
		check_id(name, sec_i, res_i1);
	endtask

	// ----------------------------------------
	// host side drivers
	// ----------------------------------------
	task automatic wait_cfg_ack(logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (cfg_ack !== level && n < WAIT_LIMIT);
		if (cfg_ack !== level) abort_run("cfg_ack never followed cfg_req");
	endtask

	task automatic wait_result_req(logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (result_req !== level && n < WAIT_LIMIT);
		if (result_req !== level) abort_run("result_req timed out");
	endtask

	// one four-phase command
	task automatic cfg_write(cfg_op_t op, id_t addr, feature_t data);
		@(posedge clk);
		cfg_op   <= op;
		cfg_addr <= addr;
		cfg_data <= data;
		cfg_req  <= 1'b1;
		wait_cfg_ack(1'b1);
		@(posedge clk);
		cfg_req <= 1'b0;
		wait_cfg_ack(1'b0);
	endtask

	task automatic write_entry(id_t id, feature_t f);
		cfg_write(OP_WRITE_FEAT, id, f);
		feat_ref[id] = f;
	endtask

	task automatic set_query(feature_t q);
		cfg_write(OP_SET_QUERY, '0, q);
		query_ref = q;
	endtask

	task automatic set_count(int n);
		cfg_write(OP_SET_COUNT, '0, feature_t'(n));
		count_ref = (n < 1) ? 1 : ((n > NUM_ENTRIES) ? NUM_ENTRIES : n);   // host side clamp
	endtask

	task automatic load_random();
		feature_t f;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			f      = $urandom;
			f[2:0] = id_t'(i);   // entries stay distinct
			write_entry(id_t'(i), f);
		end
	endtask

	// result must not move while req is up
	task automatic hold_check(string name);
		if (result_req !== 1'b1) begin
			errors++;
			$display("%s: result_req dropped before result_ack", name);
		end
		check_score(name, res_s0, min_score_0);
		check_id(name, res_i0, min_id_0);
		check_score(name, res_s1, min_score_1);
		check_id(name, res_i1, min_id_1);
	endtask

	// start, capture the result, hold ack back, then release
	task automatic run_search(string name, int ack_delay, logic poke_start);
		cfg_write(OP_START, '0, '0);
		wait_result_req(1'b1);
		res_s0 = min_score_0;
		res_i0 = min_id_0;
		res_s1 = min_score_1;
		res_i1 = min_id_1;
		if (poke_start) begin
			cfg_write(OP_START, '0, '0);   // controller busy, pulse dropped
			hold_check(name);
		end
		repeat (ack_delay) begin
			@(negedge clk);
			hold_check(name);
		end
		@(posedge clk);
		result_ack <= 1'b1;
		wait_result_req(1'b0);
		@(posedge clk);
		result_ack <= 1'b0;
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic full_search();
		int e0;
		e0 = errors;
		load_random();
		set_query($urandom);
		set_count(8);
		run_search("full_search", 0, 1'b0);
		check_model("full_search");
		report_test("full_search", e0);
	endtask

	task automatic short_count();
		int e0;
		e0 = errors;
		load_random();
		set_query(feat_ref[5]);   // slot 5 would win at 0 if counted
		set_count(5);
		run_search("short_count", 0, 1'b0);
		check_model("short_count");
		set_query(feat_ref[1]);
		set_count(1);
		run_search("short_count", 0, 1'b0);
		check_model("short_count");
		check_score("short_count", MAX_SCORE, res_s1);   // empty second place
		check_id("short_count", '0, res_i1);
		report_test("short_count", e0);
	endtask

	task automatic held_result();
		int e0;
		int stray;
		e0    = errors;
		stray = 0;
		set_query($urandom);
		set_count(8);
		run_search("held_result", 3 + int'($urandom % 20), 1'b1);
		check_model("held_result");
		repeat (50) begin   // a full search is 17 cycles
			@(negedge clk);
			if (result_req !== 1'b0) stray++;
		end
		if (stray != 0) begin
			errors++;
			$display("held_result: a start given during the wait began a new search");
		end
		report_test("held_result", e0);
	endtask

	task automatic back_to_back();
		int e0;
		e0 = errors;
		set_query(feat_ref[3]);   // exact match, score 0
		run_search("back_to_back", 0, 1'b0);
		check_model("back_to_back");
		check_score("back_to_back", '0, res_s0);
		set_query($urandom);      // a stale 0 would show here
		run_search("back_to_back", 0, 1'b0);
		check_model("back_to_back");
		report_test("back_to_back", e0);
	endtask

	task automatic count_clamp();
		int e0;
		e0 = errors;
		set_query(feat_ref[1]);
		set_count(0);             // taken as 1
		run_search("count_clamp", 0, 1'b0);
		check_model("count_clamp");
		set_query(feat_ref[7]);
		set_count(12);            // taken as 8
		run_search("count_clamp", 0, 1'b0);
		check_model("count_clamp");
		report_test("count_clamp", e0);
	endtask

	task automatic tie_break();
		int e0;
		feature_t t;
		e0 = errors;
		t  = $urandom;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			write_entry(id_t'(i), t);
		end
		set_query($urandom);
		set_count(8);
		run_search("tie_break", 0, 1'b0);
		check_model("tie_break");
		check_id("tie_break", id_t'(0), res_i0);
		check_id("tie_break", id_t'(1), res_i1);
		check_score("tie_break", sad_ref(query_ref, t), res_s1);   // second equals best
		report_test("tie_break", e0);
	endtask

	initial begin
		int seed_ret;
		cfg_req    = 1'b0;
		cfg_op     = OP_WRITE_FEAT;
		cfg_addr   = '0;
		cfg_data   = '0;
		result_ack = 1'b0;
		reset_N    = 1'b0;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		count_ref  = NUM_ENTRIES;
		query_ref  = '0;
		seed_ret   = $urandom(22);   // seeds the generator
		repeat (10) @(posedge clk);
		reset_N <= 1'b1;
		@(posedge clk);
		full_search();
		short_count();
		held_result();
		back_to_back();
		count_clamp();
		tie_break();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* oflow_match.f */
source/oflow_core_pkg.sv
source/oflow_ctrl_pkg.sv
source/oflow_feature_mem.sv
source/oflow_similarity_metric.sv
source/oflow_calc_min.sv
source/oflow_match_ctrl.sv
source/oflow_cfg_regs.sv
source/oflow_match_top.sv
tb/oflow_match_tb.sv

/* Makefile */
TOP := oflow_match_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f oflow_match.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f oflow_match.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
